/* c1Pkg.sv */
package c1Pkg;

	// One 68000 bus cycle as the chip sees it
	// addr holds address bits 23 to 17
	typedef struct packed {
		logic [6:0] addr;
		logic       nUds;
		logic       nLds;
		logic       rw;
		logic       nAs;
	} busReq_t;

	// Internal zone selects, all active low
	typedef struct packed {
		logic romZone;
		logic wramZone;
		logic portZone;
		logic ioZone;
		logic icomZone;
		logic ctrl1Zone;
		logic ctrl2Zone;
		logic statusbZone;
		logic lspcZone;
		logic cardZone;
		logic sromZone;
		logic sramZone;
	} zoneSel_t;

	// External chip strobes, all active low
	typedef struct packed {
		logic romOeL;
		logic romOeU;
		logic portOeL;
		logic portOeU;
		logic portWeL;
		logic portWeU;
		logic portAdrs;
		logic wrL;
		logic wrU;
		logic wwL;
		logic wwU;
		logic sromOeL;
		logic sromOeU;
		logic sramOeL;
		logic sramOeU;
		logic sramWeL;
		logic sramWeU;
		logic lspOe;
		logic lspWe;
		logic crdO;
		logic crdW;
		logic crdC;
		logic bitW0;
		logic bitW1;
		logic dipRd0;
		logic dipRd1;
		logic pal;
		logic ctrl1Zone;
		logic ctrl2Zone;
		logic statusbZone;
	} chipStrobes_t;

	// Request toward one wait timer
	typedef struct packed {
		logic       sel;
		logic [1:0] waitCycles;
	} waitReq_t;

	// Timer slot of each wait zone
	localparam int FastZone = 0;
	localparam int RomZone  = 1;
	localparam int PortZone = 2;
	localparam int CardZone = 3;

	localparam int DefaultWaitZones = 4;

endpackage

/* c1AddrDecode.sv */
`timescale 1ns/10ps

module c1AddrDecode #(
	parameter int NumWaitZones = c1Pkg::DefaultWaitZones,
	parameter int CardWait     = 2
) (
	input  c1Pkg::busReq_t                         bus,
	input  logic                                   nRomWait,
	input  logic                                   nPWait0,
	input  logic                                   nPWait1,
	output c1Pkg::chipStrobes_t                    strobes,
	output c1Pkg::zoneSel_t                        zoneSel,
	output c1Pkg::waitReq_t [NumWaitZones-1:0]     waitReqs
);

	logic [3:0] hiAddr;
	logic [2:0] subAddr;
	logic       c1Regs;
	logic       nValid;
	logic       nWord;
	logic       palZone;

	// A23..A20 pick the megabyte, A19..A17 the IO sub-zone
	assign hiAddr  = bus.addr[6:3];
	assign subAddr = bus.addr[2:0];

	assign nValid = bus.nAs | (bus.nLds & bus.nUds);
	assign nWord  = bus.nLds | bus.nUds;

	always_comb begin
		zoneSel.romZone  = (hiAddr != 4'h0);
		zoneSel.wramZone = (hiAddr != 4'h1);
		zoneSel.portZone = (hiAddr != 4'h2);
		zoneSel.ioZone   = (hiAddr != 4'h3);
		zoneSel.cardZone = (bus.addr[6:5] != 2'b10);
		zoneSel.sromZone = (hiAddr != 4'hC);
		zoneSel.sramZone = (hiAddr != 4'hD);

		// Even-byte registers inside the IO megabyte
		c1Regs = bus.nUds | zoneSel.ioZone;
		zoneSel.ctrl1Zone   = c1Regs | ~bus.rw | (subAddr != 3'b000);
		zoneSel.icomZone    = c1Regs | (subAddr != 3'b001);
		zoneSel.ctrl2Zone   = c1Regs | ~bus.rw | (subAddr[2:1] != 2'b01);
		zoneSel.statusbZone = c1Regs | ~bus.rw | (subAddr != 3'b100);
		zoneSel.lspcZone    = zoneSel.ioZone | (subAddr != 3'b110);
	end

	// Palette spans 4xxxxx to 7xxxxx
	assign palZone = (bus.addr[6:5] != 2'b01);

	always_comb begin
		strobes.romOeL = ~bus.rw | bus.nLds | zoneSel.romZone | bus.nAs;
		strobes.romOeU = ~bus.rw | bus.nUds | zoneSel.romZone | bus.nAs;

		strobes.portOeL  = ~bus.rw | bus.nLds | zoneSel.portZone | bus.nAs;
		strobes.portOeU  = ~bus.rw | bus.nUds | zoneSel.portZone | bus.nAs;
		strobes.portWeL  = bus.rw | bus.nLds | zoneSel.portZone | bus.nAs;
		strobes.portWeU  = bus.rw | bus.nUds | zoneSel.portZone | bus.nAs;
		strobes.portAdrs = zoneSel.portZone | nValid;

		strobes.wrL = ~bus.rw | bus.nLds | zoneSel.wramZone | bus.nAs;
		strobes.wrU = ~bus.rw | bus.nUds | zoneSel.wramZone | bus.nAs;
		strobes.wwL = bus.rw | bus.nLds | zoneSel.wramZone | bus.nAs;
		strobes.wwU = bus.rw | bus.nUds | zoneSel.wramZone | bus.nAs;

		strobes.sromOeL = ~bus.rw | bus.nLds | zoneSel.sromZone | bus.nAs;
		strobes.sromOeU = ~bus.rw | bus.nUds | zoneSel.sromZone | bus.nAs;
		strobes.sramOeL = ~bus.rw | bus.nLds | zoneSel.sramZone | bus.nAs;
		strobes.sramOeU = ~bus.rw | bus.nUds | zoneSel.sramZone | bus.nAs;
		strobes.sramWeL = bus.rw | bus.nLds | zoneSel.sramZone | bus.nAs;
		strobes.sramWeU = bus.rw | bus.nUds | zoneSel.sramZone | bus.nAs;

		// Sprite controller and card only take word accesses
		strobes.lspOe = ~bus.rw | nWord | zoneSel.lspcZone | bus.nAs;
		strobes.lspWe = bus.rw | nWord | zoneSel.lspcZone | bus.nAs;
		strobes.crdO  = ~bus.rw | nWord | zoneSel.cardZone | bus.nAs;
		strobes.crdW  = bus.rw | nWord | zoneSel.cardZone | bus.nAs;
		strobes.crdC  = strobes.crdO & strobes.crdW;

		// Odd-byte DIP reads and bit writes
		strobes.dipRd0 = bus.nLds | ~bus.rw | zoneSel.ioZone | (subAddr != 3'b000) | bus.nAs;
		strobes.dipRd1 = bus.nLds | ~bus.rw | zoneSel.ioZone | (subAddr != 3'b001) | bus.nAs;
		strobes.bitW0  = bus.nLds | bus.rw | zoneSel.ioZone | (subAddr != 3'b100) | bus.nAs;
		strobes.bitW1  = bus.nLds | bus.rw | zoneSel.ioZone | (subAddr != 3'b101) | bus.nAs;

		strobes.pal         = palZone | nValid;
		strobes.ctrl1Zone   = zoneSel.ctrl1Zone | bus.nAs;
		strobes.ctrl2Zone   = zoneSel.ctrl2Zone | bus.nAs;
		strobes.statusbZone = zoneSel.statusbZone | bus.nAs;
	end

	always_comb begin
		for (int i = 0; i < NumWaitZones; i++) begin
			waitReqs[i] = '0;
		end

		waitReqs[c1Pkg::RomZone].sel        = ~zoneSel.romZone & ~bus.nAs;
		waitReqs[c1Pkg::RomZone].waitCycles = {1'b0, ~nRomWait};

		// Port wait pins give 0 to 3 extra cycles
		waitReqs[c1Pkg::PortZone].sel        = ~zoneSel.portZone & ~bus.nAs;
		waitReqs[c1Pkg::PortZone].waitCycles = ~{nPWait1, nPWait0};

		waitReqs[c1Pkg::CardZone].sel        = ~zoneSel.cardZone & ~bus.nAs;
		waitReqs[c1Pkg::CardZone].waitCycles = 2'(CardWait);

		// Everything else acknowledges without wait states
		waitReqs[c1Pkg::FastZone].sel = ~bus.nAs & zoneSel.romZone & zoneSel.portZone
			& zoneSel.cardZone;
		waitReqs[c1Pkg::FastZone].waitCycles = 2'd0;
	end

endmodule

/* c1WaitTimer.sv */
`timescale 1ns/10ps

module c1WaitTimer (
	input  logic            CLK_68KCLK,
	input  logic            arstN,
	input  c1Pkg::waitReq_t req,
	output logic            done
);

	logic       busy;
	logic [1:0] count;

	// Wait count is taken once, at the first edge that sees sel
	always_ff @(posedge CLK_68KCLK or negedge arstN) begin
		if (!arstN) begin
			busy  <= 1'b0;
			count <= 2'd0;
			done  <= 1'b0;
		end else if (!req.sel) begin
			// Cycle over, get ready for the next one
			busy  <= 1'b0;
			count <= 2'd0;
			done  <= 1'b0;
		end else if (!busy) begin
			busy  <= 1'b1;
			count <= req.waitCycles;
		end else if (count == 2'd0) begin
			done <= 1'b1;
		end else begin
			count <= count - 2'd1;
		end
	end

endmodule

/* c1DtackMerge.sv */
`timescale 1ns/10ps

module c1DtackMerge #(
	parameter int NumWaitZones = c1Pkg::DefaultWaitZones
) (
	input  logic                    CLK_68KCLK,
	input  logic                    arstN,
	input  logic [NumWaitZones-1:0] done,
	input  logic                    nAs,
	output logic                    nDtack
);

	logic anyDone;
	logic ackHeld;

	assign anyDone = |done;

	// Keeps the acknowledge up until the master lets go of nAS,
	// even if the zone select moves under a held cycle
	always_ff @(posedge CLK_68KCLK or negedge arstN) begin
		if (!arstN) begin
			ackHeld <= 1'b0;
		end else begin
			ackHeld <= ~nAs & (ackHeld | anyDone);
		end
	end

	// Both terms are flops, so nDtack falls on the done edge
	assign nDtack = ~(anyDone | ackHeld);

endmodule

/* c1CommLatch.sv */
`timescale 1ns/10ps

module c1CommLatch (
	input  logic           CLK_68KCLK,
	input  logic           arstN,
	input  c1Pkg::busReq_t bus,
	input  logic           icomSel,
	input  logic [7:0]     dataIn,
	input  logic [7:0]     soundReply,
	output logic [7:0]     soundCmd,
	output logic           soundNmi,
	output logic [7:0]     dataOut,
	output logic           dataOutEn
);

	logic icomWr;
	logic icomRd;
	logic wrSeen;

	// icomSel is active low and already qualified by nUDS
	assign icomWr = ~icomSel & ~bus.nAs & ~bus.rw;
	assign icomRd = ~icomSel & ~bus.nAs & bus.rw;

	always_ff @(posedge CLK_68KCLK or negedge arstN) begin
		if (!arstN) begin
			wrSeen   <= 1'b0;
			soundCmd <= 8'h00;
			soundNmi <= 1'b0;
		end else begin
			wrSeen   <= icomWr;
			soundNmi <= 1'b0;
			// Only the first edge of a write cycle counts
			if (icomWr && !wrSeen) begin
				soundCmd <= dataIn;
				soundNmi <= 1'b1;
			end
		end
	end

	// Reply byte goes back on the upper data lane
	assign dataOutEn = icomRd;
	assign dataOut   = icomRd ? soundReply : 8'h00;

endmodule

/* c1System.sv */
`timescale 1ns/10ps

module c1System #(
	parameter int NumWaitZones = c1Pkg::DefaultWaitZones,
	parameter int CardWait     = 2
) (
	input  logic                CLK_68KCLK,
	input  logic                arstN,
	input  c1Pkg::busReq_t      bus,
	input  logic [7:0]          dataIn,
	input  logic                nRomWait,
	input  logic                nPWait0,
	input  logic                nPWait1,
	input  logic [7:0]          soundReply,
	output c1Pkg::chipStrobes_t strobes,
	output logic                nDtack,
	output logic [7:0]          dataOut,
	output logic                dataOutEn,
	output logic [7:0]          soundCmd,
	output logic                soundNmi
);

	c1Pkg::zoneSel_t                     zoneSel;
	c1Pkg::waitReq_t [NumWaitZones-1:0]  waitReqs;
	logic [NumWaitZones-1:0]             timerDone;

	c1AddrDecode #(
		.NumWaitZones (NumWaitZones),
		.CardWait     (CardWait)
	) addrDecode (
		.bus      (bus),
		.nRomWait (nRomWait),
		.nPWait0  (nPWait0),
		.nPWait1  (nPWait1),
		.strobes  (strobes),
		.zoneSel  (zoneSel),
		.waitReqs (waitReqs)
	);

	// One wait timer per zone slot
	for (genvar i = 0; i < NumWaitZones; i++) begin : genTimer
		c1WaitTimer waitTimer (
			.CLK_68KCLK (CLK_68KCLK),
			.arstN      (arstN),
			.req        (waitReqs[i]),
			.done       (timerDone[i])
		);
	end

	c1DtackMerge #(
		.NumWaitZones (NumWaitZones)
	) dtackMerge (
		.CLK_68KCLK (CLK_68KCLK),
		.arstN      (arstN),
		.done       (timerDone),
		.nAs        (bus.nAs),
		.nDtack     (nDtack)
	);

	c1CommLatch commLatch (
		.CLK_68KCLK (CLK_68KCLK),
		.arstN      (arstN),
		.bus        (bus),
		.icomSel    (zoneSel.icomZone),
		.dataIn     (dataIn),
		.soundReply (soundReply),
		.soundCmd   (soundCmd),
		.soundNmi   (soundNmi),
		.dataOut    (dataOut),
		.dataOutEn  (dataOutEn)
	);

endmodule

/* c1System_sva.sv */
`timescale 1ns/10ps

module c1SystemSva (
	input logic                CLK_68KCLK,
	input logic                arstN,
	input c1Pkg::busReq_t      bus,
	input logic                nDtack,
	input logic                soundNmi,
	input c1Pkg::chipStrobes_t strobes
);

	int assertFails = 0;

	// An edge that saw nAS high leaves nDtack released
	dtackReleased: assert property (@(posedge CLK_68KCLK) disable iff (!arstN)
		bus.nAs |=> nDtack)
		else begin
			assertFails++;
			$error("nDtack low after an edge with nAS high");
		end

	nmiSingle: assert property (@(posedge CLK_68KCLK) disable iff (!arstN)
		soundNmi |=> !soundNmi)
		else begin
			assertFails++;
			$error("soundNmi longer than one cycle");
		end

	// ROM, work RAM and port never share a cycle
	memExclusive: assert property (@(posedge CLK_68KCLK) disable iff (!arstN)
		$onehot0({~(strobes.romOeL & strobes.romOeU),
			~(strobes.wrL & strobes.wrU & strobes.wwL & strobes.wwU),
			~(strobes.portOeL & strobes.portOeU & strobes.portWeL & strobes.portWeU)}))
		else begin
			assertFails++;
			$error("more than one memory enable low");
		end

endmodule

bind c1System c1SystemSva sva (
	.CLK_68KCLK (CLK_68KCLK),
	.arstN      (arstN),
	.bus        (bus),
	.nDtack     (nDtack),
	.soundNmi   (soundNmi),
	.strobes    (strobes)
);

/* c1Checker.sv */
`timescale 1ns/10ps

module c1Checker (
	input  logic                CLK_68KCLK,
	input  logic                arstN,
	input  c1Pkg::busReq_t      bus,
	input  c1Pkg::chipStrobes_t strobes,
	input  logic                nDtack,
	input  logic [7:0]          soundCmd,
	input  logic                soundNmi,
	input  logic [7:0]          dataOut,
	input  logic                dataOutEn,
	input  logic [7:0]          dataIn,
	input  logic [7:0]          soundReply,
	input  c1Pkg::chipStrobes_t expStrobes,
	input  logic [1:0]          expWait,
	input  logic                expIcomWr,
	input  logic                expIcomRd
);

	int         totalErrs = 0;
	int         testErrs = 0;
	int         testsRun = 0;
	int         testsFailed = 0;
	int         cyc = 0;
	int         nmiCount = 0;
	logic       prevNAs = 1'b1;
	logic       fell = 1'b0;
	logic       riseCheck = 1'b0;
	logic       icomWrCyc = 1'b0;
	logic [7:0] dataCyc = 8'h00;

	task automatic fail(input string msg);
		$display("[FAIL] %0t ns: %s", $time, msg);
		testErrs++;
	endtask

	task automatic endTest(input string name);
		testsRun++;
		if (testErrs != 0) begin
			testsFailed++;
		end
		$display("Test %0d %s: %s, %0d errors", testsRun, name,
			(testErrs == 0) ? "ok" : "failed", testErrs);
		totalErrs += testErrs;
		testErrs = 0;
	endtask

	task automatic summary();
		$display("Tests run %0d, failed %0d, errors %0d", testsRun, testsFailed, totalErrs);
	endtask

	// Sampled on the falling edge, half a cycle away from the stimulus
	always @(negedge CLK_68KCLK) begin
		if (!arstN) begin
			if (nDtack !== 1'b1 || soundNmi !== 1'b0 || soundCmd !== 8'h00) begin
				fail("outputs not at reset values");
			end
			prevNAs = 1'b1;
		end else begin
			if (strobes !== expStrobes) begin
				fail($sformatf("strobes %h expected %h", strobes, expStrobes));
			end
			if (dataOutEn !== expIcomRd) begin
				fail("dataOutEn does not match an ICOM read");
			end else if (expIcomRd && dataOut !== soundReply) begin
				fail($sformatf("dataOut %h expected %h", dataOut, soundReply));
			end
			if (riseCheck) begin
				riseCheck = 1'b0;
				if (nDtack !== 1'b1) begin
					fail("nDtack still low one edge after nAS rose");
				end
			end
			if (!bus.nAs) begin
				if (prevNAs) begin
					cyc = 0;
					fell = 1'b0;
					nmiCount = 0;
					icomWrCyc = expIcomWr;
					dataCyc = dataIn;
				end else begin
					cyc++;
				end
				if (nDtack === 1'b0 && !fell) begin
					fell = 1'b1;
					if (cyc != int'(expWait) + 2) begin
						fail($sformatf("nDtack after %0d cycles, expected %0d",
							cyc - 1, int'(expWait) + 1));
					end
				end else if (nDtack !== 1'b0 && fell) begin
					fail("nDtack released while nAS held");
				end
				if (!fell && cyc == int'(expWait) + 4) begin
					$display("No acknowledge: nDtack never fell for the cycle at %0t ns", $time);
					testErrs++;
				end
				if (soundNmi) begin
					nmiCount++;
				end
			end else if (!prevNAs) begin
				riseCheck = 1'b1;
				if (icomWrCyc) begin
					if (nmiCount != 1) begin
						fail($sformatf("%0d soundNmi pulses on an ICOM write", nmiCount));
					end
					if (soundCmd !== dataCyc) begin
						fail($sformatf("soundCmd %h expected %h", soundCmd, dataCyc));
					end
				end else if (nmiCount != 0) begin
					fail("soundNmi without an ICOM write");
				end
			end
			prevNAs = bus.nAs;
		end
	end

endmodule

/* tbC1System.sv */
`timescale 1ns/10ps

module tbC1System;

	localparam int CardWait    = 2;
	localparam int MaxWait     = 3;
	localparam int MaxHold     = 8;
	localparam int TotalCycles = 230;
	// Each cycle also has its hold and two idle cycles
	localparam int TimeoutNs   = (16 + TotalCycles * (MaxWait + 4 + MaxHold + 2)) * 10;

	logic                CLK_68KCLK;
	logic                arstN;
	c1Pkg::busReq_t      bus;
	logic [7:0]          dataIn;
	logic                nRomWait;
	logic                nPWait0;
	logic                nPWait1;
	logic [7:0]          soundReply;
	c1Pkg::chipStrobes_t strobes;
	logic                nDtack;
	logic [7:0]          dataOut;
	logic                dataOutEn;
	logic [7:0]          soundCmd;
	logic                soundNmi;
	c1Pkg::chipStrobes_t expStrobes;
	logic [1:0]          expWait;
	logic                expIcomWr;
	logic                expIcomRd;
	int                  seed;
	logic [31:0]         r;
	logic [1:0]          stb;

	// Expected strobes, in positive logic per zone
	function automatic c1Pkg::chipStrobes_t refStrobes(input c1Pkg::busReq_t b);
		c1Pkg::chipStrobes_t s;
		logic                rd;
		logic                lo;
		logic                up;
		logic                word;
		logic [2:0]          sub;
		s = '1;
		rd = b.rw;
		lo = !b.nLds;
		up = !b.nUds;
		word = lo && up;
		sub = b.addr[2:0];
		if (!b.nAs) begin
			case (b.addr[6:3])
				4'h0: begin
					s.romOeL = !(rd && lo);
					s.romOeU = !(rd && up);
				end
				4'h1: begin
					s.wrL = !(rd && lo);
					s.wrU = !(rd && up);
					s.wwL = !(!rd && lo);
					s.wwU = !(!rd && up);
				end
				4'h2: begin
					s.portOeL = !(rd && lo);
					s.portOeU = !(rd && up);
					s.portWeL = !(!rd && lo);
					s.portWeU = !(!rd && up);
					s.portAdrs = !(lo || up);
				end
				4'h3: begin
					s.ctrl1Zone = !(up && rd && sub == 3'd0);
					s.dipRd0 = !(lo && rd && sub == 3'd0);
					s.dipRd1 = !(lo && rd && sub == 3'd1);
					s.ctrl2Zone = !(up && rd && (sub == 3'd2 || sub == 3'd3));
					s.statusbZone = !(up && rd && sub == 3'd4);
					s.bitW0 = !(lo && !rd && sub == 3'd4);
					s.bitW1 = !(lo && !rd && sub == 3'd5);
					s.lspOe = !(word && rd && sub == 3'd6);
					s.lspWe = !(word && !rd && sub == 3'd6);
				end
				4'h4, 4'h5, 4'h6, 4'h7: s.pal = !(lo || up);
				4'h8, 4'h9, 4'hA, 4'hB: begin
					s.crdO = !(word && rd);
					s.crdW = !(word && !rd);
					s.crdC = !word;
				end
				4'hC: begin
					s.sromOeL = !(rd && lo);
					s.sromOeU = !(rd && up);
				end
				4'hD: begin
					s.sramOeL = !(rd && lo);
					s.sramOeU = !(rd && up);
					s.sramWeL = !(!rd && lo);
					s.sramWeU = !(!rd && up);
				end
				default: s = '1;
			endcase
		end
		refStrobes = s;
	endfunction

	function automatic logic [1:0] refWait(input c1Pkg::busReq_t b, input logic nRw,
		input logic [1:0] nPw);
		case (b.addr[6:3])
			4'h0: refWait = nRw ? 2'd0 : 2'd1;
			4'h2: refWait = 2'd3 - nPw;
			4'h8, 4'h9, 4'hA, 4'hB: refWait = 2'(CardWait);
			default: refWait = 2'd0;
		endcase
	endfunction

	always_comb begin
		expStrobes = refStrobes(bus);
		expWait = refWait(bus, nRomWait, {nPWait1, nPWait0});
		expIcomWr = !bus.nAs && !bus.nUds && bus.addr == 7'h19 && !bus.rw;
		expIcomRd = !bus.nAs && !bus.nUds && bus.addr == 7'h19 && bus.rw;
	end

	c1System #(
		.NumWaitZones (c1Pkg::DefaultWaitZones),
		.CardWait     (CardWait)
	) DUT (
		.CLK_68KCLK (CLK_68KCLK),
		.arstN      (arstN),
		.bus        (bus),
		.dataIn     (dataIn),
		.nRomWait   (nRomWait),
		.nPWait0    (nPWait0),
		.nPWait1    (nPWait1),
		.soundReply (soundReply),
		.strobes    (strobes),
		.nDtack     (nDtack),
		.dataOut    (dataOut),
		.dataOutEn  (dataOutEn),
		.soundCmd   (soundCmd),
		.soundNmi   (soundNmi)
	);

	c1Checker chk (
		.CLK_68KCLK (CLK_68KCLK),
		.arstN      (arstN),
		.bus        (bus),
		.strobes    (strobes),
		.nDtack     (nDtack),
		.soundCmd   (soundCmd),
		.soundNmi   (soundNmi),
		.dataOut    (dataOut),
		.dataOutEn  (dataOutEn),
		.dataIn     (dataIn),
		.soundReply (soundReply),
		.expStrobes (expStrobes),
		.expWait    (expWait),
		.expIcomWr  (expIcomWr),
		.expIcomRd  (expIcomRd)
	);

	initial begin
		CLK_68KCLK = 1'b0;
		forever #5 CLK_68KCLK = ~CLK_68KCLK;
	end

	initial begin
		#(TimeoutNs);
		$display("Watchdog expired, the bus stopped responding");
		$display("SOME TESTS FAILED");
		$finish;
	end

	// One bus cycle, held until nDtack or a cycle limit
	task automatic busCycle(input logic [6:0] addr, input logic rw, input logic [1:0] nStb,
		input logic nRw, input logic [1:0] nPw, input logic [7:0] data, input int hold);
		int n;
		@(posedge CLK_68KCLK);
		bus.addr <= addr;
		bus.rw <= rw;
		bus.nUds <= nStb[1];
		bus.nLds <= nStb[0];
		bus.nAs <= 1'b0;
		nRomWait <= nRw;
		nPWait1 <= nPw[1];
		nPWait0 <= nPw[0];
		dataIn <= data;
		n = 0;
		do begin
			@(posedge CLK_68KCLK);
			n++;
		end while (nDtack && n < 12);
		repeat (hold) @(posedge CLK_68KCLK);
		bus.nAs <= 1'b1;
		repeat (2) @(posedge CLK_68KCLK);
	endtask

	initial begin
		seed = 39;
		arstN = 1'b0;
		bus = '{addr: 7'h00, nUds: 1'b1, nLds: 1'b1, rw: 1'b1, nAs: 1'b1};
		dataIn = 8'h00;
		nRomWait = 1'b1;
		nPWait0 = 1'b1;
		nPWait1 = 1'b1;
		soundReply = 8'h00;
		repeat (16) @(posedge CLK_68KCLK);
		arstN <= 1'b1;
		chk.endTest("reset state");

		repeat (200) begin
			r = $random(seed);
			stb = (r[9:8] == 2'b11) ? 2'b00 : r[9:8];
			busCycle(r[6:0], r[7], stb, r[12], r[11:10], r[20:13], int'(r[23:22]));
		end
		chk.endTest("random decode and wait");

		busCycle(7'h00, 1'b1, 2'b00, 1'b1, 2'b11, 8'h00, 0);
		busCycle(7'h00, 1'b1, 2'b00, 1'b0, 2'b11, 8'h00, 0);
		for (int p = 0; p < 4; p++) begin
			busCycle(7'h10, 1'b0, 2'b00, 1'b1, 2'(p), 8'h11, 0);
		end
		busCycle(7'h40, 1'b1, 2'b00, 1'b1, 2'b11, 8'h00, 0);
		busCycle(7'h08, 1'b0, 2'b10, 1'b1, 2'b11, 8'h22, 0);
		busCycle(7'h60, 1'b1, 2'b00, 1'b1, 2'b11, 8'h00, 0);
		chk.endTest("wait states per zone");

		busCycle(7'h00, 1'b1, 2'b00, 1'b0, 2'b11, 8'h00, MaxHold);
		busCycle(7'h08, 1'b1, 2'b00, 1'b1, 2'b11, 8'h00, MaxHold);
		busCycle(7'h10, 1'b1, 2'b01, 1'b1, 2'b00, 8'h00, MaxHold);
		chk.endTest("held nAS");

		soundReply <= 8'hA5;
		busCycle(7'h19, 1'b0, 2'b01, 1'b1, 2'b11, 8'h3C, 1);
		busCycle(7'h19, 1'b0, 2'b01, 1'b1, 2'b11, 8'hC3, 4);
		busCycle(7'h19, 1'b1, 2'b01, 1'b1, 2'b11, 8'h00, 2);
		chk.endTest("sound latch");

		chk.summary();
		if (chk.totalErrs == 0 && DUT.sva.assertFails == 0) begin
			$display("ALL TESTS PASSED");
		end else begin
			$display("SOME TESTS FAILED");
		end
		$finish;
	end

endmodule

/* c1System.f */
c1Pkg.sv
c1AddrDecode.sv
c1WaitTimer.sv
c1DtackMerge.sv
c1CommLatch.sv
c1System.sv
c1System_sva.sv
c1Checker.sv
tbC1System.sv

/* Makefile */
TOP = tbC1System

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert --top-module $(TOP) -f c1System.f -o simv
	@out=$$(./obj_dir/simv); \
	echo "$$out"; \
	echo "$$out" | grep -q "ALL TESTS PASSED"

clean:
	rm -rf obj_dir
